// File: hdl/fdc_config.svh
// ==========================================================
// build-time constants for the floppy controller
// include where timer lengths or the image width are needed
// ==========================================================

`ifndef FDC_CONFIG_SVH
`define FDC_CONFIG_SVH

// image RAM address width, 64 KB
`define FDC_IMG_AW 16

// controller timing, all in clk_sys cycles
`define FDC_SETTLE_CYCLES 400
`define FDC_SEARCH_CYCLES 64
`define FDC_BYTE_DELAY 16
`define FDC_WATCHDOG_CYCLES 512

`endif

// File: hdl/fdc_bus_pkg.sv
// ==========================================================
// CPU-side types: register map, command opcodes, status byte
// and the host bus bundle
// ==========================================================

`default_nettype none

package fdc_bus_pkg;

	typedef enum logic [1:0] {
		REG_CMD_STATUS = 2'd0,
		REG_TRACK      = 2'd1,
		REG_SECTOR     = 2'd2,
		REG_DATA       = 2'd3
	} reg_addr_t;

	// upper nibble of the command byte, 2..7 are the step variants
	typedef enum logic [3:0] {
		OP_RESTORE   = 4'h0,
		OP_SEEK      = 4'h1,
		OP_READ      = 4'h8,
		OP_READ_M    = 4'h9,
		OP_WRITE     = 4'ha,
		OP_WRITE_M   = 4'hb,
		OP_FORCE_INT = 4'hd
	} cmd_op_t;

	typedef struct packed {
		logic       rd;    // one-cycle strobes
		logic       wr;
		reg_addr_t  addr;
		logic [7:0] wdata;
	} host_bus_t;

	typedef struct packed {
		logic not_ready;
		logic write_prot;
		logic head_loaded;
		logic seek_err;
		logic crc_err;
		logic track0;
		logic index;
		logic busy;
	} status_type1_t;

	typedef struct packed {
		logic not_ready;
		logic write_prot;
		logic write_fault;
		logic rnf;
		logic crc_err;
		logic lost_data;
		logic drq;
		logic busy;
	} status_type2_t;

	// one byte, meaning depends on the last command type
	typedef union packed {
		status_type1_t type1;
		status_type2_t type2;
	} status_t;

endpackage

`default_nettype wire

// File: hdl/fdc_disk_pkg.sv
// ==========================================================
// media-side types: image addressing, geometry, head and
// sector transfer requests passed between controller blocks
// ==========================================================

`default_nettype none

`include "fdc_config.svh"

package fdc_disk_pkg;

	typedef logic [`FDC_IMG_AW-1:0] img_addr_t;

	typedef logic [2:0] size_code_t;

	typedef struct packed {
		logic [7:0]  spt;        // sectors per track
		logic [10:0] sector_len; // bytes per sector
	} geom_t;

	typedef enum logic [1:0] {
		HEAD_RESTORE,
		HEAD_SEEK,
		HEAD_STEP
	} head_op_t;

	typedef struct packed {
		head_op_t   op;
		logic       dir_given; // step carries its own direction
		logic       dir_out;   // out means towards track 0
		logic [7:0] target;
	} head_req_t;

	typedef struct packed {
		img_addr_t   base;
		logic [10:0] length;
		logic        write;
	} xfer_req_t;

endpackage

`default_nettype wire

// File: hdl/fdc_image_ram.sv
// ==========================================================
// disk image store, dual-port byte RAM
// port A loads the image, port B serves the controller
// ==========================================================

`default_nettype none
`timescale 1ns/1ps

`include "fdc_config.svh"

module fdc_image_ram import fdc_disk_pkg::*; (
	input  logic       clk_sys,
	input  img_addr_t  a_addr,
	input  logic       a_we,
	input  logic [7:0] a_wdata,
	input  img_addr_t  b_addr,
	input  logic       b_we,
	input  logic [7:0] b_wdata,
	output logic [7:0] b_rdata
);

	logic [7:0] mem [0:(1 << `FDC_IMG_AW) - 1];

	always_ff @(posedge clk_sys) begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		if (b_we)
			mem[b_addr] <= b_wdata;
		b_rdata <= b_we ? b_wdata : mem[b_addr]; // registered, write-first
	end

endmodule

`default_nettype wire

// File: hdl/fdc_head.sv
// ==========================================================
// head position for type I commands
// moves at head_start, head_done after the settle time
// ==========================================================

`default_nettype none
`timescale 1ns/1ps

`include "fdc_config.svh"

module fdc_head import fdc_disk_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       head_start,
	input  head_req_t  head_req,
	output logic [7:0] disk_track,
	output logic       head_done
);

	localparam int TW = $clog2(`FDC_SETTLE_CYCLES);

	logic [TW-1:0] cnt;
	logic          active;
	logic          dir_r;    // last step direction, 1 = out
	logic          step_out;

	assign step_out = head_req.dir_given ? head_req.dir_out : dir_r;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			disk_track <= 8'd0;
			dir_r      <= 1'b0;
			cnt        <= '0;
			active     <= 1'b0;
			head_done  <= 1'b0;
		end else begin
			head_done <= 1'b0;
			if (head_start) begin
				case (head_req.op)
					HEAD_RESTORE: disk_track <= 8'd0;
					HEAD_SEEK:    disk_track <= head_req.target;
					default: begin
						if (head_req.dir_given)
							dir_r <= head_req.dir_out;
						if (!step_out)
							disk_track <= disk_track + 1'b1;
						else if (disk_track != 8'd0) // stops at track 0
							disk_track <= disk_track - 1'b1;
					end
				endcase
				cnt    <= TW'(`FDC_SETTLE_CYCLES - 1);
				active <= 1'b1;
			end else if (active) begin
				if (cnt == '0) begin
					head_done <= 1'b1;
					active    <= 1'b0;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/fdc_geometry.sv
// ==========================================================
// sector address in the disk image from track, side, sector
// latches image size and layout when loading ends
// ==========================================================

`default_nettype none
`timescale 1ns/1ps

`include "fdc_config.svh"

module fdc_geometry import fdc_disk_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       load_active,
	input  img_addr_t  load_addr,
	input  logic       layout,
	input  size_code_t size_code,
	input  logic [7:0] disk_track,
	input  logic       side,
	input  logic [7:0] sector_reg,
	output geom_t      geom,
	output img_addr_t  sector_base
);

	logic [`FDC_IMG_AW:0] img_size;
	logic                 layout_r;  // 1 = all of side 0, then side 1
	logic                 load_q;
	logic [8:0]           track_idx;
	logic [31:0]          lin;
	img_addr_t            half_off;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			load_q   <= 1'b0;
			img_size <= '0;
			layout_r <= 1'b0;
		end else begin
			load_q <= load_active;
			if (load_q && !load_active) begin
				img_size <= {1'b0, load_addr} + 1'b1;
				layout_r <= layout;
			end
		end
	end

	always_comb begin
		case (size_code)
			3'd0:    geom = '{spt: 8'd26, sector_len: 11'd128};
			3'd1:    geom = '{spt: 8'd16, sector_len: 11'd256};
			3'd2:    geom = '{spt: 8'd9,  sector_len: 11'd512};
			3'd3:    geom = '{spt: 8'd5,  sector_len: 11'd1024};
			3'd4:    geom = '{spt: 8'd10, sector_len: 11'd512};
			default: geom = '{spt: 8'd0,  sector_len: 11'd0}; // every sector misses
		endcase
	end

	assign track_idx = layout_r ? {1'b0, disk_track} : {disk_track, side};
	assign half_off  = (layout_r && side) ? img_size[`FDC_IMG_AW:1] : '0;

	// sectors are numbered from 1
	assign lin = (track_idx * geom.spt + sector_reg - 32'd1) * geom.sector_len;

	assign sector_base = img_addr_t'(lin) + half_off;

endmodule

`default_nettype wire

// File: hdl/fdc_xfer.sv
// ==========================================================
// byte pacing for sector transfers: delay, DRQ, watchdog
// owns image RAM port B during reads and writes
// ==========================================================

`default_nettype none
`timescale 1ns/1ps

`include "fdc_config.svh"

module fdc_xfer import fdc_disk_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       xfer_start,
	input  xfer_req_t  xfer_req,
	input  logic       xfer_abort,
	input  logic       data_access,
	input  logic [7:0] wdata,
	output logic       drq,
	output logic       lost_pulse,
	output logic       xfer_done,
	output img_addr_t  ram_addr,
	output logic       ram_we,
	output logic [7:0] ram_wdata
);

	localparam int TW = $clog2(`FDC_WATCHDOG_CYCLES);

	typedef enum logic [1:0] {
		X_IDLE,
		X_DELAY, // byte not yet due
		X_WAIT   // DRQ up, watchdog running
	} xfer_state_t;

	xfer_state_t   state;
	img_addr_t     ptr;
	logic [10:0]   left;
	logic          wr_mode;
	logic [TW-1:0] timer;
	logic          take;
	logic          bark;

	assign take = state == X_WAIT && data_access;
	assign bark = state == X_WAIT && !data_access && timer == '0;

	assign ram_addr  = ptr;
	assign ram_we    = take && wr_mode; // missed bytes are never written
	assign ram_wdata = wdata;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= X_IDLE;
			ptr        <= '0;
			left       <= 11'd0;
			wr_mode    <= 1'b0;
			timer      <= '0;
			drq        <= 1'b0;
			lost_pulse <= 1'b0;
			xfer_done  <= 1'b0;
		end else begin
			lost_pulse <= bark && !xfer_abort;
			xfer_done  <= 1'b0;
			if (xfer_abort) begin
				drq   <= 1'b0;
				state <= X_IDLE;
			end else if (xfer_start) begin
				ptr     <= xfer_req.base;
				left    <= xfer_req.length;
				wr_mode <= xfer_req.write;
				timer   <= TW'(`FDC_BYTE_DELAY - 1);
				state   <= X_DELAY;
			end else begin
				case (state)
					X_DELAY: begin
						if (timer == '0) begin
							drq   <= 1'b1;
							timer <= TW'(`FDC_WATCHDOG_CYCLES - 1);
							state <= X_WAIT;
						end else begin
							timer <= timer - 1'b1;
						end
					end
					X_WAIT: begin
						if (take || bark) begin
							drq <= 1'b0;
							if (left == 11'd1) begin
								xfer_done <= 1'b1;
								state     <= X_IDLE;
							end else begin
								ptr   <= ptr + 1'b1;
								left  <= left - 1'b1;
								timer <= TW'(`FDC_BYTE_DELAY - 1);
								state <= X_DELAY;
							end
						end else begin
							timer <= timer - 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/fdc_cmd_seq.sv
// ==========================================================
// register file, command decode and command sequencing
// drives head and transfer requests, status and INTRQ
// ==========================================================

`default_nettype none
`timescale 1ns/1ps

`include "fdc_config.svh"

module fdc_cmd_seq import fdc_bus_pkg::*, fdc_disk_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  host_bus_t  bus,
	input  logic       side,
	input  logic       ready,
	input  logic       wp,
	input  logic [7:0] disk_track,
	input  geom_t      geom,
	input  img_addr_t  sector_base,
	input  logic       head_done,
	input  logic       drq,
	input  logic       lost_pulse,
	input  logic       xfer_done,
	input  logic [7:0] ram_rdata,
	output logic [7:0] rdata,
	output logic       busy,
	output logic       intrq,
	output logic [7:0] sector_reg,
	output logic       head_start,
	output head_req_t  head_req,
	output logic       xfer_start,
	output xfer_req_t  xfer_req,
	output logic       xfer_abort,
	output logic       data_access
);

	localparam int TW = $clog2(`FDC_SETTLE_CYCLES);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_HEAD,   // type I, waiting for the head
		ST_SEARCH, // sector search delay
		ST_XFER,   // bytes moving
		ST_WP,     // write refused, busy for a while
		ST_END
	} seq_state_t;

	seq_state_t    state;
	logic [7:0]    track_reg;
	logic [7:0]    data_reg;
	status_t       stat;      // sticky bits only
	status_t       status_rd;
	logic          t2_view;
	logic          wr_cmd;
	logic          multi;
	logic          upd_track;
	logic          side_chk;
	logic          side_exp;
	logic [TW-1:0] timer;
	cmd_op_t       op;
	logic          cmd_wr;
	logic          idle;
	logic          bad_sector;

	assign op          = cmd_op_t'(bus.wdata[7:4]);
	assign cmd_wr      = bus.wr && bus.addr == REG_CMD_STATUS;
	assign idle        = state == ST_IDLE;
	assign busy        = !idle;
	assign data_access = (bus.rd || bus.wr) && bus.addr == REG_DATA;
	assign head_start  = cmd_wr && idle && !bus.wdata[7];
	assign bad_sector  = sector_reg == 8'd0 || sector_reg > geom.spt
		|| (side_chk && side_exp != side);

	assign xfer_req = '{base: sector_base, length: geom.sector_len, write: wr_cmd};

	always_comb begin
		head_req.target    = data_reg;
		head_req.dir_given = bus.wdata[6]; // only set for step-in/out
		head_req.dir_out   = bus.wdata[5];
		case (op)
			OP_RESTORE: head_req.op = HEAD_RESTORE;
			OP_SEEK:    head_req.op = HEAD_SEEK;
			default:    head_req.op = HEAD_STEP;
		endcase
	end

	// ==========================================================
	// status byte, live bits laid over the sticky ones
	// ==========================================================
	always_comb begin
		status_rd = stat;
		if (t2_view) begin
			status_rd.type2.not_ready  = ~ready;
			status_rd.type2.write_prot = wp;
			status_rd.type2.crc_err    = 1'b0;
			status_rd.type2.drq        = drq;
			status_rd.type2.busy       = busy;
		end else begin
			status_rd.type1.not_ready  = ~ready;
			status_rd.type1.write_prot = wp;
			status_rd.type1.crc_err    = 1'b0;
			status_rd.type1.track0     = disk_track == 8'd0;
			status_rd.type1.index      = 1'b0; // no index pulse
			status_rd.type1.busy       = busy;
		end
	end

	always_comb begin
		case (bus.addr)
			REG_CMD_STATUS: rdata = status_rd;
			REG_TRACK:      rdata = track_reg;
			REG_SECTOR:     rdata = sector_reg;
			default:        rdata = (t2_view && !wr_cmd && !idle) ? ram_rdata : data_reg;
		endcase
	end

	// ==========================================================
	// sequencer and register writes
	// ==========================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			track_reg  <= 8'd0;
			sector_reg <= 8'd0;
			data_reg   <= 8'd0;
			stat       <= '0;
			t2_view    <= 1'b0;
			wr_cmd     <= 1'b0;
			multi      <= 1'b0;
			upd_track  <= 1'b0;
			side_chk   <= 1'b0;
			side_exp   <= 1'b0;
			timer      <= '0;
			intrq      <= 1'b0;
			xfer_start <= 1'b0;
			xfer_abort <= 1'b0;
		end else begin
			xfer_start <= 1'b0;
			xfer_abort <= 1'b0;
			if (cmd_wr || (bus.rd && bus.addr == REG_CMD_STATUS))
				intrq <= 1'b0;
			if (lost_pulse)
				stat.type2.lost_data <= 1'b1;

			case (state)
				ST_HEAD: if (head_done) begin
					if (upd_track)
						track_reg <= disk_track; // head already moved
					intrq <= 1'b1;
					state <= ST_IDLE;
				end
				ST_WP: begin
					if (timer == '0)
						state <= ST_END;
					else
						timer <= timer - 1'b1;
				end
				ST_SEARCH: begin
					if (!ready) begin
						stat.type2.rnf <= 1'b1;
						state <= ST_END;
					end else if (timer != '0) begin
						timer <= timer - 1'b1;
					end else if (bad_sector) begin
						stat.type2.rnf <= 1'b1;
						state <= ST_END;
					end else begin
						xfer_start <= 1'b1;
						state <= ST_XFER;
					end
				end
				ST_XFER: if (xfer_done) begin
					if (multi) begin // next sector, runs off the track end
						sector_reg <= sector_reg + 1'b1;
						timer <= TW'(`FDC_SEARCH_CYCLES - 1);
						state <= ST_SEARCH;
					end else begin
						state <= ST_END;
					end
				end
				ST_END: begin
					intrq <= 1'b1;
					state <= ST_IDLE;
				end
				default: ;
			endcase

			if (bus.wr) begin
				case (bus.addr)
					REG_CMD_STATUS: begin
						if (op == OP_FORCE_INT) begin
							t2_view <= 1'b0;
							stat <= '0;
							if (!idle) begin
								xfer_abort <= 1'b1;
								intrq <= 1'b1;
								state <= ST_IDLE;
							end
						end else if (idle && !bus.wdata[7]) begin
							// restore, seek, step
							t2_view <= 1'b0;
							stat.type1.head_loaded <= bus.wdata[3];
							stat.type1.seek_err <= 1'b0;
							upd_track <= bus.wdata[7:5] == 3'd0 || bus.wdata[4];
							state <= ST_HEAD;
						end else if (idle && (op == OP_READ || op == OP_READ_M
								|| op == OP_WRITE || op == OP_WRITE_M)) begin
							t2_view <= 1'b1;
							stat.type2.write_fault <= 1'b0;
							stat.type2.rnf <= 1'b0;
							stat.type2.lost_data <= 1'b0;
							multi <= bus.wdata[4];
							wr_cmd <= bus.wdata[5];
							side_exp <= bus.wdata[3];
							side_chk <= bus.wdata[1];
							if (bus.wdata[5] && wp) begin
								stat.type2.write_fault <= 1'b1;
								timer <= TW'(`FDC_SETTLE_CYCLES - 1);
								state <= ST_WP;
							end else begin
								timer <= TW'(`FDC_SEARCH_CYCLES - 1);
								state <= ST_SEARCH;
							end
						end
					end
					REG_TRACK:  if (idle) track_reg <= bus.wdata;
					REG_SECTOR: if (idle) sector_reg <= bus.wdata;
					default:    data_reg <= bus.wdata;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/fdc_top.sv
// ==========================================================
// floppy controller top, WD1793 style register set
// image is loaded through the load port, CPU uses host_bus_t
// ==========================================================

`default_nettype none
`timescale 1ns/1ps

module fdc_top import fdc_bus_pkg::*, fdc_disk_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  host_bus_t  bus,
	input  logic       load_active,
	input  img_addr_t  load_addr,
	input  logic [7:0] load_data,
	input  logic       load_wr,
	input  size_code_t size_code,
	input  logic       layout,
	input  logic       side,
	input  logic       ready,
	input  logic       wp,
	output logic [7:0] rdata,
	output logic       drq,
	output logic       busy,
	output logic       intrq
);

	logic [7:0] disk_track;
	logic [7:0] sector_reg;
	geom_t      geom;
	img_addr_t  sector_base;
	logic       head_start;
	head_req_t  head_req;
	logic       head_done;
	logic       xfer_start;
	xfer_req_t  xfer_req;
	logic       xfer_abort;
	logic       xfer_done;
	logic       data_access;
	logic       lost_pulse;
	img_addr_t  ram_addr;
	logic       ram_we;
	logic [7:0] ram_wdata;
	logic [7:0] ram_rdata;

	fdc_cmd_seq u_cmd_seq (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.bus         (bus),
		.side        (side),
		.ready       (ready),
		.wp          (wp),
		.disk_track  (disk_track),
		.geom        (geom),
		.sector_base (sector_base),
		.head_done   (head_done),
		.drq         (drq),
		.lost_pulse  (lost_pulse),
		.xfer_done   (xfer_done),
		.ram_rdata   (ram_rdata),
		.rdata       (rdata),
		.busy        (busy),
		.intrq       (intrq),
		.sector_reg  (sector_reg),
		.head_start  (head_start),
		.head_req    (head_req),
		.xfer_start  (xfer_start),
		.xfer_req    (xfer_req),
		.xfer_abort  (xfer_abort),
		.data_access (data_access)
	);

	fdc_geometry u_geometry (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.load_active (load_active),
		.load_addr   (load_addr),
		.layout      (layout),
		.size_code   (size_code),
		.disk_track  (disk_track),
		.side        (side),
		.sector_reg  (sector_reg),
		.geom        (geom),
		.sector_base (sector_base)
	);

	fdc_head u_head (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.head_start (head_start),
		.head_req   (head_req),
		.disk_track (disk_track),
		.head_done  (head_done)
	);

	fdc_xfer u_xfer (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.xfer_start  (xfer_start),
		.xfer_req    (xfer_req),
		.xfer_abort  (xfer_abort),
		.data_access (data_access),
		.wdata       (bus.wdata),
		.drq         (drq),
		.lost_pulse  (lost_pulse),
		.xfer_done   (xfer_done),
		.ram_addr    (ram_addr),
		.ram_we      (ram_we),
		.ram_wdata   (ram_wdata)
	);

	fdc_image_ram u_image_ram (
		.clk_sys (clk_sys),
		.a_addr  (load_addr), // loader side
		.a_we    (load_wr),
		.a_wdata (load_data),
		.b_addr  (ram_addr),  // controller side
		.b_we    (ram_we),
		.b_wdata (ram_wdata),
		.b_rdata (ram_rdata)
	);

endmodule

`default_nettype wire

// File: tests/tb_fdc.sv
// ==========================================================
// testbench for the floppy controller top level
// loads a pseudo-random image, then applies a step table
// ==========================================================

`default_nettype none
`timescale 1ns/1ps

`include "fdc_config.svh"

module tb_fdc import fdc_bus_pkg::*, fdc_disk_pkg::*; ();

	localparam int         PERIOD     = 40;
	localparam int         IMG_BYTES  = 49152;  // 48 KB image
	localparam size_code_t SIZE_CODE  = 3'd1;   // 16 x 256
	localparam logic [7:0] DATA_TRACK = 8'd2;   // all sector steps use this track
	localparam logic [1:0] SET_SIDE   = 2'd0;
	localparam logic [1:0] SET_READY  = 2'd1;
	localparam logic [1:0] SET_WP     = 2'd2;

	typedef enum logic [3:0] {
		S_LOAD,     // reload image, val = layout
		S_SET,      // media level, addr selects which
		S_WR,
		S_RD,       // val = expected
		S_WAIT_INT, // val[0] = DRQ must stay low, n = bytes left to expire
		S_RD_DATA,  // val = sector, n = bytes
		S_WR_DATA,
		S_IDLE,
		S_PINS      // val = {busy, drq, intrq}
	} step_op_t;

	typedef struct packed {
		step_op_t    op;
		logic [1:0]  addr;
		logic [7:0]  val;
		logic [31:0] n;
	} step_t;

	logic       clk_sys;
	logic       rst_n;
	host_bus_t  bus;
	logic       load_active;
	img_addr_t  load_addr;
	logic [7:0] load_data;
	logic       load_wr;
	size_code_t size_code;
	logic       layout;
	logic       side;
	logic       ready;
	logic       wp;
	logic [7:0] rdata;
	logic       drq;
	logic       busy;
	logic       intrq;

	logic [7:0]  model [0:(1 << `FDC_IMG_AW) - 1]; // expected image contents
	step_t       steps [$];
	logic [31:0] lcg_state;
	int          limit_cycles;
	int          cycle_count;

	fdc_top u_dut (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.bus         (bus),
		.load_active (load_active),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_wr     (load_wr),
		.size_code   (size_code),
		.layout      (layout),
		.side        (side),
		.ready       (ready),
		.wp          (wp),
		.rdata       (rdata),
		.drq         (drq),
		.busy        (busy),
		.intrq       (intrq)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ==========================================================
	// helpers
	// ==========================================================
	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	function automatic int sectors_per_track(input size_code_t code);
		case (code)
			3'd0:    return 26;
			3'd1:    return 16;
			3'd2:    return 9;
			3'd3:    return 5;
			3'd4:    return 10;
			default: return 0;
		endcase
	endfunction

	function automatic int bytes_per_sector(input size_code_t code);
		case (code)
			3'd0:    return 128;
			3'd1:    return 256;
			3'd3:    return 1024;
			3'd2,
			3'd4:    return 512;
			default: return 0;
		endcase
	endfunction

	// byte address of a sector in the image, from the layout rule
	function automatic img_addr_t expected_base(input logic [7:0] trk, input logic [7:0] sec);
		int idx;
		int base;
		idx  = layout ? int'(trk) : int'(trk) * 2 + int'(side);
		base = (idx * sectors_per_track(size_code) + int'(sec) - 1)
			* bytes_per_sector(size_code);
		if (layout && side)
			base = base + IMG_BYTES / 2; // side 1 in the upper half
		return img_addr_t'(base);
	endfunction

	function automatic int step_budget(input step_t s);
		case (s.op)
			S_LOAD:     return IMG_BYTES + 4;
			S_WR, S_RD: return 2;
			S_WAIT_INT: return `FDC_SETTLE_CYCLES + `FDC_SEARCH_CYCLES + 8
				+ int'(s.n) * (`FDC_BYTE_DELAY + `FDC_WATCHDOG_CYCLES + 2);
			S_RD_DATA,
			S_WR_DATA:  return `FDC_SEARCH_CYCLES + 8 + int'(s.n) * (`FDC_BYTE_DELAY + 3);
			S_IDLE:     return int'(s.n);
			default:    return 1;
		endcase
	endfunction

	task automatic check_equal(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got 0x%02h, expected 0x%02h",
				$time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic add_step(input step_op_t op, input logic [1:0] addr,
			input logic [7:0] val, input logic [31:0] n);
		step_t s;
		s.op   = op;
		s.addr = addr;
		s.val  = val;
		s.n    = n;
		steps.push_back(s);
	endtask

	// all bus tasks start and end on a falling edge
	task automatic bus_write(input logic [1:0] addr, input logic [7:0] val);
		bus.wr    = 1'b1;
		bus.addr  = reg_addr_t'(addr);
		bus.wdata = val;
		@(negedge clk_sys);
		bus.wr = 1'b0;
	endtask

	task automatic bus_read_check(input logic [1:0] addr, input logic [7:0] exp,
			input string what);
		bus.rd   = 1'b1;
		bus.addr = reg_addr_t'(addr);
		#1;
		check_equal(rdata, exp, what);
		@(negedge clk_sys);
		bus.rd = 1'b0;
	endtask

	task automatic wait_drq();
		while (!drq)
			@(negedge clk_sys);
	endtask

	task automatic load_image(input logic lay);
		int i;
		layout      = lay;
		load_active = 1'b1;
		for (i = 0; i < IMG_BYTES; i++) begin
			load_addr = img_addr_t'(i);
			load_data = model[img_addr_t'(i)];
			load_wr   = 1'b1;
			@(negedge clk_sys);
		end
		load_wr     = 1'b0;
		load_active = 1'b0; // last address stays on load_addr
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic run_step(input step_t s);
		int        i;
		img_addr_t base;
		img_addr_t a;
		logic [7:0] b;
		case (s.op)
			S_LOAD: load_image(s.val[0]);
			S_SET: begin
				case (s.addr)
					SET_SIDE:  side = s.val[0];
					SET_READY: ready = s.val[0];
					default:   wp = s.val[0];
				endcase
			end
			S_WR: bus_write(s.addr, s.val);
			S_RD: bus_read_check(s.addr, s.val, $sformatf("read of register %0d", s.addr));
			S_WAIT_INT: begin
				while (!intrq) begin
					if (s.val[0])
						check_equal({7'd0, drq}, 8'd0, "DRQ during refused write");
					@(negedge clk_sys);
				end
			end
			S_RD_DATA: begin
				base = expected_base(DATA_TRACK, s.val);
				for (i = 0; i < int'(s.n); i++) begin
					a = base + img_addr_t'(i);
					wait_drq();
					bus_read_check(REG_DATA, model[a],
						$sformatf("byte %0d of sector %0d", i, s.val));
				end
			end
			S_WR_DATA: begin
				base = expected_base(DATA_TRACK, s.val);
				for (i = 0; i < int'(s.n); i++) begin
					a = base + img_addr_t'(i);
					b = next_random();
					model[a] = b;
					wait_drq();
					bus_write(REG_DATA, b);
				end
			end
			S_IDLE: repeat (s.n) @(negedge clk_sys);
			default: check_equal({5'd0, busy, drq, intrq}, s.val, "busy/drq/intrq pins");
		endcase
	endtask

	// ==========================================================
	// step table
	// ==========================================================
	task automatic build_table();
		// registers and restore
		add_step(S_LOAD, 2'd0, 8'd0, 32'd0);
		add_step(S_SET, SET_SIDE, 8'd1, 32'd0);
		add_step(S_WR, REG_TRACK, 8'h33, 32'd0);
		add_step(S_RD, REG_TRACK, 8'h33, 32'd0);
		add_step(S_WR, REG_SECTOR, 8'h07, 32'd0);
		add_step(S_RD, REG_SECTOR, 8'h07, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h00, 32'd0);  // restore
		add_step(S_PINS, 2'd0, 8'b100, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_TRACK, 8'h00, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h04, 32'd0);  // track0 only
		add_step(S_PINS, 2'd0, 8'b000, 32'd0);
		// seek, step-in with update, step-out without
		add_step(S_WR, REG_DATA, 8'h05, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h10, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_TRACK, 8'h05, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h50, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_TRACK, 8'h06, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h60, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_TRACK, 8'h06, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		add_step(S_WR, REG_DATA, DATA_TRACK, 32'd0);  // park head on the data track
		add_step(S_WR, REG_CMD_STATUS, 8'h10, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		// single-sector reads, layout 0 then layout 1
		add_step(S_WR, REG_SECTOR, 8'd4, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h80, 32'd0);
		add_step(S_RD_DATA, 2'd0, 8'd4, 32'd256);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		add_step(S_LOAD, 2'd0, 8'd1, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h80, 32'd0);
		add_step(S_RD_DATA, 2'd0, 8'd4, 32'd256);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		// write, read back, write protect
		add_step(S_WR, REG_SECTOR, 8'd6, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'ha0, 32'd0);
		add_step(S_WR_DATA, 2'd0, 8'd6, 32'd256);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h80, 32'd0);
		add_step(S_RD_DATA, 2'd0, 8'd6, 32'd256);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		add_step(S_SET, SET_WP, 8'd1, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'ha0, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd1, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h60, 32'd0);  // write_prot, write_fault
		add_step(S_SET, SET_WP, 8'd0, 32'd0);
		// multi-sector off the track end, sector 0, not ready
		add_step(S_WR, REG_SECTOR, 8'd15, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h90, 32'd0);
		add_step(S_RD_DATA, 2'd0, 8'd15, 32'd256);
		add_step(S_RD_DATA, 2'd0, 8'd16, 32'd256);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h10, 32'd0);
		add_step(S_RD, REG_SECTOR, 8'd17, 32'd0);
		add_step(S_WR, REG_SECTOR, 8'd0, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h80, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h10, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'hd0, 32'd0);  // force interrupt while idle
		add_step(S_PINS, 2'd0, 8'b000, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		add_step(S_SET, SET_READY, 8'd0, 32'd0);
		add_step(S_WR, REG_SECTOR, 8'd3, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h80, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h90, 32'd0);
		add_step(S_SET, SET_READY, 8'd1, 32'd0);
		// lost data, then force interrupt during a read
		add_step(S_WR, REG_SECTOR, 8'd7, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h80, 32'd0);
		add_step(S_WAIT_INT, 2'd0, 8'd0, 32'd256);  // every byte expires
		add_step(S_RD, REG_CMD_STATUS, 8'h04, 32'd0);
		add_step(S_WR, REG_SECTOR, 8'd8, 32'd0);
		add_step(S_WR, REG_CMD_STATUS, 8'h80, 32'd0);
		add_step(S_IDLE, 2'd0, 8'd0, 32'd100);
		add_step(S_WR, REG_CMD_STATUS, 8'hd0, 32'd0);
		add_step(S_IDLE, 2'd0, 8'd0, 32'd2);
		add_step(S_PINS, 2'd0, 8'b001, 32'd0);
		add_step(S_RD, REG_CMD_STATUS, 8'h00, 32'd0);
		add_step(S_PINS, 2'd0, 8'b000, 32'd0);
	endtask

	// ==========================================================
	// main sequence and run limit
	// ==========================================================
	initial begin
		int i;
		int total;
		rst_n       = 1'b0;
		bus         = '0;
		load_active = 1'b0;
		load_addr   = '0;
		load_data   = 8'd0;
		load_wr     = 1'b0;
		size_code   = SIZE_CODE;
		layout      = 1'b0;
		side        = 1'b0;
		ready       = 1'b1;
		wp          = 1'b0;
		lcg_state   = 32'h09d9_f25a;
		for (i = 0; i < (1 << `FDC_IMG_AW); i++)
			model[img_addr_t'(i)] = next_random();
		build_table();
		total = 0;
		for (i = 0; i < steps.size(); i++)
			total += step_budget(steps[i]);
		limit_cycles = total + total / 4 + 100;

		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);

		for (i = 0; i < steps.size(); i++)
			run_step(steps[i]);

		$display("** PASS **");
		$finish;
	end

	initial begin
		cycle_count = 0;
		wait (limit_cycles != 0);
		while (cycle_count < limit_cycles) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", limit_cycles);
		$display("** FAIL **");
		$fatal(1, "simulation timed out");
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/fdc_bus_pkg.sv
hdl/fdc_disk_pkg.sv
hdl/fdc_image_ram.sv
hdl/fdc_head.sv
hdl/fdc_geometry.sv
hdl/fdc_xfer.sv
hdl/fdc_cmd_seq.sv
hdl/fdc_top.sv
tests/tb_fdc.sv

// File: run.sh
#!/bin/sh
# build and run the floppy controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f files.f --top-module tb_fdc -o tb_fdc
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_fdc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
	echo "result: passed"
	exit 0
fi
echo "result: failed"
exit 1
